/* sim.f */
cpu_types_pkg.sv
wb_bus_pkg.sv
wb_stage.sv
regfile.sv
csr_file.sv
wb_top.sv
tb_wb_top.sv

/* Makefile */
.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"

test:
	verilator --binary --timing --assert --top-module tb_wb_top -f sim.f \
		--Mdir obj_dir -o tb_wb_top
	./obj_dir/tb_wb_top

clean:
	rm -rf obj_dir

/* tb_wb_top.sv */
module tb_wb_top
  import cpu_types_pkg::*;
  import wb_bus_pkg::*;
();

  localparam int CSR_COUNT       = 8;
  localparam int CLK_PERIOD      = 4;
  localparam int HANDSHAKE_LIMIT = 50;
  // run length in cycles: reset, pair transfers, full state sweeps, blocked cycles
  localparam int NUM_TRANSFERS   = 21;
  localparam int NUM_SWEEPS      = 8;
  localparam int RUN_CYCLES      = 5 + NUM_TRANSFERS * 4 + NUM_SWEEPS * 8 + 3;
  localparam int WATCHDOG_CYCLES = 2 * RUN_CYCLES + 100;

  logic        clk;
  logic        reset;
  logic        pair_valid;
  ex_wb_slot_t slot1;
  ex_wb_slot_t slot2;
  logic        nblock;
  logic        ready;
  fwd_t        fwd1;
  fwd_t        fwd2;
  reg_addr_t   rf_raddr [NUM_RF_READ];
  word_t       rf_rdata [NUM_RF_READ];
  csr_addr_t   csr_raddr;
  word_t       csr_rdata;

  // shadow state of the architectural registers
  word_t       model_regs [NUM_REGS];
  word_t       model_csr [csr_addr_t];
  integer      seed;
  pc_t         next_pc;

  wb_top #(
    .CSR_COUNT (CSR_COUNT)
  ) i_dut (
    .clk        (clk),
    .reset      (reset),
    .pair_valid (pair_valid),
    .slot1      (slot1),
    .slot2      (slot2),
    .nblock     (nblock),
    .ready      (ready),
    .fwd1       (fwd1),
    .fwd2       (fwd2),
    .rf_raddr   (rf_raddr),
    .rf_rdata   (rf_rdata),
    .csr_raddr  (csr_raddr),
    .csr_rdata  (csr_rdata)
  );

  always #2 clk = ~clk;

  function automatic ex_wb_slot_t make_slot(logic valid, logic ok, logic gr_we, reg_addr_t dest,
                                            word_t result, logic csr_we, csr_addr_t csr_addr,
                                            word_t csr_wdata);
    ex_wb_slot_t s;
    s = '0;
    s.valid     = valid;
    s.ok        = ok;
    s.gr_we     = gr_we;
    s.dest      = dest;
    s.result    = result;
    s.csr_we    = csr_we;
    s.csr_addr  = csr_addr;
    s.csr_wdata = csr_wdata;
    return s;
  endfunction

  function automatic ex_wb_slot_t gr_slot(reg_addr_t dest, word_t result);
    return make_slot(1'b1, 1'b1, 1'b1, dest, result, 1'b0, '0, '0);
  endfunction

  function automatic ex_wb_slot_t csr_slot(csr_addr_t addr, word_t data);
    return make_slot(1'b1, 1'b1, 1'b0, '0, '0, 1'b1, addr, data);
  endfunction

  function automatic word_t rnd_word();
    return $random(seed);
  endfunction

  // four fixed csrs, save registers from 0x30 on
  function automatic bit csr_implemented(csr_addr_t a);
    return (a == 14'h000) || (a == 14'h001) || (a == 14'h005) || (a == 14'h006) ||
           (int'(a) >= 'h30 && int'(a) < 'h30 + CSR_COUNT - 4);
  endfunction

  function automatic void model_csr_write(csr_addr_t a, word_t d);
    if (csr_implemented(a)) begin
      model_csr[a] = (a == 14'h005) ? (d & 32'h3) : d;
    end
  endfunction

  function automatic word_t csr_expected(csr_addr_t a);
    return model_csr.exists(a) ? model_csr[a] : '0;
  endfunction

  // slot2 is younger, so applying it second lets it win a shared dest
  function automatic void model_commit(ex_wb_slot_t s1, ex_wb_slot_t s2);
    bit c1;
    bit c2;
    c1 = s1.valid && s1.ok;
    c2 = c1 && s2.valid && s2.ok;
    if (c1 && s1.gr_we && s1.dest != '0) begin
      model_regs[s1.dest] = s1.result;
    end
    if (c2 && s2.gr_we && s2.dest != '0) begin
      model_regs[s2.dest] = s2.result;
    end
    if (s1.csr_we) begin
      if (c1) begin
        model_csr_write(s1.csr_addr, s1.csr_wdata);
      end
    end else if (c2 && s2.csr_we) begin
      model_csr_write(s2.csr_addr, s2.csr_wdata);
    end
  endfunction

  // csr addresses swept alongside the register groups
  function automatic csr_addr_t csr_probe(int i);
    case (i)
      0: return 14'h000;
      1: return 14'h001;
      2: return 14'h005;
      3: return 14'h006;
      4: return 14'h030;
      5: return 14'h033;
      6: return 14'h034;
      default: return 14'h002;
    endcase
  endfunction

  task automatic check_word(string what, word_t got, word_t exp);
    assert (got === exp) else begin
      $display("mismatch at time %0t: %s is %h, expected %h", $time, what, got, exp);
      $display("test failed");
      $fatal(1, "value check failed");
    end
  endtask

  task automatic check_fwd(string name, fwd_t f, ex_wb_slot_t s);
    check_word({name, " valid"}, word_t'(f.valid), word_t'(s.valid));
    if (s.valid) begin
      check_word({name, " gr_we"}, word_t'(f.gr_we), word_t'(s.gr_we));
      check_word({name, " dest"}, word_t'(f.dest), word_t'(s.dest));
      check_word({name, " result"}, f.result, s.result);
    end
  endtask

  // sweeps all registers four at a time, one csr per group
  task automatic check_state();
    csr_addr_t ca;
    for (int g = 0; g < NUM_REGS / NUM_RF_READ; g++) begin
      ca = csr_probe(g);
      @(posedge clk);
      for (int p = 0; p < NUM_RF_READ; p++) begin
        rf_raddr[p] <= reg_addr_t'(g * NUM_RF_READ + p);
      end
      csr_raddr <= ca;
      @(negedge clk);
      for (int p = 0; p < NUM_RF_READ; p++) begin
        check_word($sformatf("r%0d", g * NUM_RF_READ + p), rf_rdata[p],
                   model_regs[g * NUM_RF_READ + p]);
      end
      check_word($sformatf("csr 0x%0h", ca), csr_rdata, csr_expected(ca));
    end
  endtask

  task automatic transfer_pair(ex_wb_slot_t s1, ex_wb_slot_t s2);
    int    waited;
    word_t old1;
    word_t old2;
    waited = 0;
    s1.pc = next_pc;
    s2.pc = next_pc + 32'd4;
    next_pc = next_pc + 32'd8;
    @(posedge clk);
    pair_valid <= 1'b1;
    slot1      <= s1;
    slot2      <= s2;
    @(negedge clk);
    while (!ready) begin
      waited++;
      if (waited > HANDSHAKE_LIMIT) begin
        $display("ready never came back high while a pair was waiting");
        $display("test failed");
        $fatal(1, "handshake timeout");
      end
      @(negedge clk);
    end
    // accept edge
    @(posedge clk);
    pair_valid  <= 1'b0;
    slot1       <= '0;
    slot2       <= '0;
    rf_raddr[0] <= s1.dest;
    rf_raddr[1] <= s2.dest;
    old1 = model_regs[s1.dest];
    old2 = model_regs[s2.dest];
    model_commit(s1, s2);
    @(negedge clk);
    check_fwd("fwd1", fwd1, s1);
    check_fwd("fwd2", fwd2, s2);
    // writes not visible yet
    check_word("slot1 dest before write", rf_rdata[0], old1);
    check_word("slot2 dest before write", rf_rdata[1], old2);
    @(posedge clk);
    @(negedge clk);
    check_word("fwd1 valid after bubble", word_t'(fwd1.valid), '0);
    check_word("fwd2 valid after bubble", word_t'(fwd2.valid), '0);
    check_word("slot1 dest after write", rf_rdata[0], model_regs[s1.dest]);
    check_word("slot2 dest after write", rf_rdata[1], model_regs[s2.dest]);
  endtask

  task automatic dual_destinations();
    transfer_pair(gr_slot(5'd3, rnd_word()), gr_slot(5'd7, rnd_word()));
    // r0 must stay zero
    transfer_pair(gr_slot(5'd0, rnd_word()), gr_slot(5'd9, rnd_word()));
    check_state();
  endtask

  task automatic same_destination();
    transfer_pair(gr_slot(5'd12, rnd_word()), gr_slot(5'd12, rnd_word()));
    transfer_pair(gr_slot(5'd13, rnd_word()),
                  make_slot(1'b1, 1'b0, 1'b1, 5'd13, rnd_word(), 1'b0, '0, '0));
    check_state();
  endtask

  task automatic in_order_commit();
    transfer_pair(make_slot(1'b0, 1'b1, 1'b1, 5'd20, rnd_word(), 1'b0, '0, '0),
                  make_slot(1'b1, 1'b1, 1'b1, 5'd15, rnd_word(), 1'b1, 14'h001, rnd_word()));
    transfer_pair(make_slot(1'b1, 1'b0, 1'b1, 5'd21, rnd_word(), 1'b1, 14'h006, rnd_word()),
                  make_slot(1'b1, 1'b1, 1'b1, 5'd16, rnd_word(), 1'b1, 14'h001, rnd_word()));
    check_state();
  endtask

  task automatic csr_selection();
    transfer_pair(csr_slot(14'h006, rnd_word()), csr_slot(14'h006, rnd_word()));
    transfer_pair(gr_slot(5'd4, rnd_word()), csr_slot(14'h030, rnd_word()));
    transfer_pair(csr_slot(14'h034, rnd_word()), csr_slot(14'h002, rnd_word()));
    transfer_pair(csr_slot(14'h005, 32'hffff_ffff), gr_slot(5'd5, rnd_word()));
    transfer_pair(csr_slot(14'h000, rnd_word()), csr_slot(14'h033, rnd_word()));
    check_state();
  endtask

  // pair waits behind a low nblock, then goes through once
  task automatic blocked_flow();
    @(posedge clk);
    nblock <= 1'b0;
    fork
      transfer_pair(gr_slot(5'd22, rnd_word()), gr_slot(5'd23, rnd_word()));
      begin
        repeat (3) begin
          @(negedge clk);
          check_word("ready while blocked", word_t'(ready), '0);
          check_word("fwd1 valid while blocked", word_t'(fwd1.valid), '0);
        end
        check_state();
        @(posedge clk);
        nblock <= 1'b1;
      end
    join
    transfer_pair(gr_slot(5'd22, rnd_word()), gr_slot(5'd24, rnd_word()));
    check_state();
  endtask

  task automatic random_burst();
    word_t       r;
    ex_wb_slot_t s1;
    ex_wb_slot_t s2;
    for (int i = 0; i < 8; i++) begin
      r  = rnd_word();
      s1 = make_slot(1'b1, r[0] | r[1], r[2], r[7:3], rnd_word(), r[8], csr_probe(int'(r[11:9])),
                     rnd_word());
      s2 = make_slot(r[12], r[13] | r[14], r[15], r[20:16], rnd_word(), r[21],
                     csr_probe(int'(r[24:22])), rnd_word());
      transfer_pair(s1, s2);
    end
    check_state();
  endtask

  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("watchdog expired before the tests finished");
    $display("test failed");
    $fatal(1, "watchdog timeout");
  end

  initial begin
    seed       = 67203;
    next_pc    = 32'h1c00_0000;
    clk        = 1'b0;
    reset      = 1'b1;
    pair_valid = 1'b0;
    slot1      = '0;
    slot2      = '0;
    nblock     = 1'b1;
    csr_raddr  = '0;
    for (int p = 0; p < NUM_RF_READ; p++) begin
      rf_raddr[p] = '0;
    end
    for (int i = 0; i < NUM_REGS; i++) begin
      model_regs[i] = '0;
    end
    repeat (5) @(posedge clk);
    reset <= 1'b0;
    check_state();
    dual_destinations();
    same_destination();
    in_order_commit();
    csr_selection();
    blocked_flow();
    random_burst();
    $display("test passed");
    $finish;
  end

endmodule

/* wb_top.sv */
module wb_top
  import cpu_types_pkg::*;
  import wb_bus_pkg::*;
#(
  parameter int CSR_COUNT = 8
) (
  input  logic        clk,
  input  logic        reset,
  // execute side
  input  logic        pair_valid,
  input  ex_wb_slot_t slot1,
  input  ex_wb_slot_t slot2,
  input  logic        nblock,
  output logic        ready,
  output fwd_t        fwd1,
  output fwd_t        fwd2,
  // register read ports
  input  reg_addr_t   rf_raddr [NUM_RF_READ],
  output word_t       rf_rdata [NUM_RF_READ],
  // csr read port
  input  csr_addr_t   csr_raddr,
  output word_t       csr_rdata
);

  rf_write_t wr1;
  rf_write_t wr2;
  logic      csr_we;
  csr_addr_t csr_waddr;
  word_t     csr_wdata;

  wb_stage i_wb_stage (
    .clk        (clk),
    .reset      (reset),
    .pair_valid (pair_valid),
    .slot1      (slot1),
    .slot2      (slot2),
    .nblock     (nblock),
    .ready      (ready),
    .wr1        (wr1),
    .wr2        (wr2),
    .csr_we     (csr_we),
    .csr_addr   (csr_waddr),
    .csr_wdata  (csr_wdata),
    .fwd1       (fwd1),
    .fwd2       (fwd2)
  );

  regfile i_regfile (
    .clk   (clk),
    .reset (reset),
    .wr1   (wr1),
    .wr2   (wr2),
    .raddr (rf_raddr),
    .rdata (rf_rdata)
  );

  // csr count comes from above
  csr_file #(
    .CSR_COUNT (CSR_COUNT)
  ) i_csr_file (
    .clk   (clk),
    .reset (reset),
    .we    (csr_we),
    .waddr (csr_waddr),
    .wdata (csr_wdata),
    .raddr (csr_raddr),
    .rdata (csr_rdata)
  );

endmodule

/* csr_file.sv */
module csr_file
  import cpu_types_pkg::*;
#(
  parameter int CSR_COUNT = 8
) (
  input  logic      clk,
  input  logic      reset,
  input  logic      we,
  input  csr_addr_t waddr,
  input  word_t     wdata,
  input  csr_addr_t raddr,
  output word_t     rdata
);

  // four fixed csrs, the rest are save registers
  localparam int NUM_SAVE = CSR_COUNT - 4;

  localparam csr_addr_t CSR_CRMD  = 14'h000;
  localparam csr_addr_t CSR_PRMD  = 14'h001;
  localparam csr_addr_t CSR_ESTAT = 14'h005;
  localparam csr_addr_t CSR_ERA   = 14'h006;
  localparam csr_addr_t SAVE_BASE = 14'h030;

  word_t      crmd_q;
  word_t      prmd_q;
  word_t      era_q;
  // software interrupt bits only
  logic [1:0] estat_is_q;
  word_t      save_q [NUM_SAVE];

  always_ff @(posedge clk) begin
    if (reset) begin
      crmd_q     <= '0;
      prmd_q     <= '0;
      era_q      <= '0;
      estat_is_q <= '0;
      for (int i = 0; i < NUM_SAVE; i++) begin
        save_q[i] <= '0;
      end
    end else if (we) begin
      case (waddr)
        CSR_CRMD:  crmd_q     <= wdata;
        CSR_PRMD:  prmd_q     <= wdata;
        CSR_ESTAT: estat_is_q <= wdata[1:0];
        CSR_ERA:   era_q      <= wdata;
        default: begin
          // unknown addresses match nothing and fall away
          for (int i = 0; i < NUM_SAVE; i++) begin
            if (waddr == SAVE_BASE + csr_addr_t'(i)) begin
              save_q[i] <= wdata;
            end
          end
        end
      endcase
    end
  end

  always_comb begin
    rdata = '0;
    case (raddr)
      CSR_CRMD:  rdata = crmd_q;
      CSR_PRMD:  rdata = prmd_q;
      CSR_ESTAT: rdata = {30'b0, estat_is_q};
      CSR_ERA:   rdata = era_q;
      default: begin
        for (int i = 0; i < NUM_SAVE; i++) begin
          if (raddr == SAVE_BASE + csr_addr_t'(i)) begin
            rdata = save_q[i];
          end
        end
      end
    endcase
  end

endmodule

/* regfile.sv */
module regfile
  import cpu_types_pkg::*;
  import wb_bus_pkg::*;
(
  input  logic      clk,
  input  logic      reset,
  input  rf_write_t wr1,
  input  rf_write_t wr2,
  input  reg_addr_t raddr [NUM_RF_READ],
  output word_t     rdata [NUM_RF_READ]
);

  // r0 has no storage
  word_t regs [1:NUM_REGS-1];

  logic wen1;
  logic wen2;

  // writes to r0 are dropped
  assign wen1 = wr1.we && (wr1.addr != '0);
  assign wen2 = wr2.we && (wr2.addr != '0);

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 1; i < NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else begin
      if (wen1) begin
        regs[wr1.addr] <= wr1.data;
      end
      // port 2 is the younger slot
      if (wen2) begin
        regs[wr2.addr] <= wr2.data;
      end
    end
  end

  // plain reads, a write shows up after the edge
  always_comb begin
    for (int p = 0; p < NUM_RF_READ; p++) begin
      if (raddr[p] == '0) begin
        rdata[p] = '0;
      end else begin
        rdata[p] = regs[raddr[p]];
      end
    end
  end

  // writeback resolves same-destination pairs before they get here
  a_no_dual_write: assert property (
    @(posedge clk) disable iff (reset)
    !(wen1 && wen2 && (wr1.addr == wr2.addr))
  ) else $error("both write ports hit register %0d", wr1.addr);

endmodule

/* wb_stage.sv */
module wb_stage
  import cpu_types_pkg::*;
  import wb_bus_pkg::*;
(
  input  logic        clk,
  input  logic        reset,
  input  logic        pair_valid,
  input  ex_wb_slot_t slot1,
  input  ex_wb_slot_t slot2,
  input  logic        nblock,
  output logic        ready,
  output rf_write_t   wr1,
  output rf_write_t   wr2,
  output logic        csr_we,
  output csr_addr_t   csr_addr,
  output word_t       csr_wdata,
  output fwd_t        fwd1,
  output fwd_t        fwd2
);

  logic        accept;
  logic        v1_q;
  logic        v2_q;
  ex_wb_slot_t s1_q;
  ex_wb_slot_t s2_q;
  logic        commit1;
  logic        commit2;
  logic        gr_wr1;
  logic        gr_wr2;
  logic        same_dest;

  // stage drains every cycle, only the external block holds execute back
  assign ready  = nblock;
  assign accept = pair_valid && ready;

  // slot valid bits, a bubble is loaded whenever no pair transfers
  always_ff @(posedge clk) begin
    if (reset) begin
      v1_q <= 1'b0;
      v2_q <= 1'b0;
    end else begin
      v1_q <= accept && slot1.valid;
      v2_q <= accept && slot2.valid;
    end
  end

  // payload of the writeback register
  always_ff @(posedge clk) begin
    if (accept) begin
      s1_q <= slot1;
      s2_q <= slot2;
    end
  end

  // in-order commit: slot2 only follows a committing slot1
  assign commit1 = v1_q && s1_q.ok;
  assign commit2 = commit1 && v2_q && s2_q.ok;

  assign gr_wr1    = commit1 && s1_q.gr_we;
  assign gr_wr2    = commit2 && s2_q.gr_we;
  assign same_dest = (s1_q.dest == s2_q.dest);

  // younger slot wins on a shared destination, so slot1 steps aside
  assign wr1 = '{
    we:   gr_wr1 && !(gr_wr2 && same_dest),
    addr: s1_q.dest,
    data: s1_q.result
  };

  assign wr2 = '{
    we:   gr_wr2,
    addr: s2_q.dest,
    data: s2_q.result
  };

  // one csr write per cycle, slot1 has priority
  always_comb begin
    if (s1_q.csr_we) begin
      csr_we    = commit1;
      csr_addr  = s1_q.csr_addr;
      csr_wdata = s1_q.csr_wdata;
    end else begin
      csr_we    = commit2 && s2_q.csr_we;
      csr_addr  = s2_q.csr_addr;
      csr_wdata = s2_q.csr_wdata;
    end
  end

  // bypass data straight from the writeback register
  assign fwd1 = '{
    valid:  v1_q,
    gr_we:  s1_q.gr_we,
    dest:   s1_q.dest,
    result: s1_q.result
  };

  assign fwd2 = '{
    valid:  v2_q,
    gr_we:  s2_q.gr_we,
    dest:   s2_q.dest,
    result: s2_q.result
  };

  // a slot2 register write needs a valid, clean slot1 accepted one cycle earlier
  a_slot2_after_slot1: assert property (
    @(posedge clk) disable iff (reset)
    wr2.we |-> $past(accept && slot1.valid && slot1.ok)
  ) else $error("slot2 wrote a register without slot1 committing");

endmodule

/* wb_bus_pkg.sv */
package wb_bus_pkg;

  import cpu_types_pkg::*;

  // one execute result on its way into writeback
  typedef struct packed {
    // slot holds an instruction
    logic      valid;
    // no exception raised, slot may commit
    logic      ok;
    logic      gr_we;
    reg_addr_t dest;
    word_t     result;
    logic      csr_we;
    csr_addr_t csr_addr;
    word_t     csr_wdata;
    pc_t       pc;
  } ex_wb_slot_t;

  // one register file write port
  typedef struct packed {
    logic      we;
    reg_addr_t addr;
    word_t     data;
  } rf_write_t;

  // bypass bundle seen by execute for one slot
  typedef struct packed {
    logic      valid;
    logic      gr_we;
    reg_addr_t dest;
    word_t     result;
  } fwd_t;

  // bundle widths, handy when packing into wider buses
  localparam int EX_WB_SLOT_W = $bits(ex_wb_slot_t);
  localparam int RF_WRITE_W   = $bits(rf_write_t);
  localparam int FWD_W        = $bits(fwd_t);

endpackage

/* cpu_types_pkg.sv */
package cpu_types_pkg;

  // base widths of the integer datapath
  localparam int XLEN       = 32;
  localparam int REG_ADDR_W = 5;
  localparam int CSR_ADDR_W = 14;

  // data word carried through the pipe
  typedef logic [XLEN-1:0] word_t;

  // instruction address
  typedef logic [XLEN-1:0] pc_t;

  // general register index
  typedef logic [REG_ADDR_W-1:0] reg_addr_t;

  // csr number as encoded in the csr instructions
  typedef logic [CSR_ADDR_W-1:0] csr_addr_t;

  // general register count, r0 included
  localparam int NUM_REGS = 2 ** REG_ADDR_W;

  // combinational read ports, two per issue slot
  localparam int NUM_RF_READ = 4;

endpackage
